// ==== src/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [15:0] lc3b_imm;   // imm5 sext or imm4 zext
    typedef logic [2:0]  lc3b_cc;    // {n, z, p}

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        lc3b_alu_op_pass,
        lc3b_alu_op_add,
        lc3b_alu_op_and,
        lc3b_alu_op_not,
        lc3b_alu_op_sll,
        lc3b_alu_op_srl,
        lc3b_alu_op_sra
    } lc3b_alu_op;

    typedef enum logic [1:0] {
        lc3b_alu_mux_sel_sr2,
        lc3b_alu_mux_sel_imm5,
        lc3b_alu_mux_sel_imm4
    } lc3b_alu_mux_sel;

    typedef struct packed {
        lc3b_reg         regfile_sr1;
        lc3b_reg         regfile_sr2;
        lc3b_alu_mux_sel alu_mux_sel;
        lc3b_alu_op      alu_op;
        logic            cc_load;
        lc3b_reg         regfile_dest;
        logic            regfile_load;
    } lc3b_control_word;

    localparam lc3b_cc CC_RESET = 3'b010;   // Z set out of reset

endpackage : lc3b_types

`default_nettype wire

// ==== src/ex_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// one decoded instruction handed from decode to execute
interface ex_bus_if;

    logic                         valid;
    lc3b_types::lc3b_control_word ctrl;      // only meaningful with valid
    lc3b_types::lc3b_word         sr1_data;
    lc3b_types::lc3b_word         sr2_data;
    lc3b_types::lc3b_imm          imm;

    modport decode (
        output valid, ctrl, sr1_data, sr2_data, imm
    );

    modport execute (
        input valid, ctrl, sr1_data, sr2_data, imm
    );

endinterface : ex_bus_if

`default_nettype wire

// ==== src/control_rom.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_rom (
    input  lc3b_types::lc3b_word         ir,
    output lc3b_types::lc3b_control_word ctrl
);

    lc3b_types::lc3b_opcode opcode;
    lc3b_types::lc3b_reg    dest;
    lc3b_types::lc3b_reg    sr1;
    lc3b_types::lc3b_reg    sr2;

    assign opcode = lc3b_types::lc3b_opcode'(ir[15:12]);
    assign dest   = ir[11:9];
    assign sr1    = ir[8:6];
    assign sr2    = ir[2:0];

    always_comb begin
        ctrl = '0;   // unknown opcodes fall through as a no-op

        case (opcode)
            lc3b_types::op_add: begin
                ctrl.regfile_sr1 = sr1;
                ctrl.regfile_sr2 = sr2;
                if (ir[5]) begin
                    ctrl.alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm5;
                end else begin
                    ctrl.alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_sr2;
                end
                ctrl.alu_op       = lc3b_types::lc3b_alu_op_add;
                ctrl.cc_load      = 1'b1;
                ctrl.regfile_dest = dest;
                ctrl.regfile_load = 1'b1;
            end

            lc3b_types::op_and: begin
                ctrl.regfile_sr1 = sr1;
                ctrl.regfile_sr2 = sr2;
                if (ir[5]) begin
                    ctrl.alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm5;
                end else begin
                    ctrl.alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_sr2;
                end
                ctrl.alu_op       = lc3b_types::lc3b_alu_op_and;
                ctrl.cc_load      = 1'b1;
                ctrl.regfile_dest = dest;
                ctrl.regfile_load = 1'b1;
            end

            lc3b_types::op_not: begin
                ctrl.regfile_sr1  = sr1;
                ctrl.alu_op       = lc3b_types::lc3b_alu_op_not;
                ctrl.cc_load      = 1'b1;
                ctrl.regfile_dest = dest;
                ctrl.regfile_load = 1'b1;
            end

            lc3b_types::op_shf: begin
                ctrl.regfile_sr1 = sr1;
                ctrl.alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm4;
                if (!ir[4]) begin
                    ctrl.alu_op = lc3b_types::lc3b_alu_op_sll;
                end else if (!ir[5]) begin
                    ctrl.alu_op = lc3b_types::lc3b_alu_op_srl;   // logical
                end else begin
                    ctrl.alu_op = lc3b_types::lc3b_alu_op_sra;   // arithmetic
                end
                ctrl.cc_load      = 1'b1;
                ctrl.regfile_dest = dest;
                ctrl.regfile_load = 1'b1;
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule : control_rom

`default_nettype wire

// ==== src/regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  we,
    input  lc3b_types::lc3b_reg  waddr,
    input  lc3b_types::lc3b_word wdata,
    input  lc3b_types::lc3b_reg  raddr1,
    input  lc3b_types::lc3b_reg  raddr2,
    output lc3b_types::lc3b_word rdata1,
    output lc3b_types::lc3b_word rdata2
);

    lc3b_types::lc3b_word regs [8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;   // all registers start at zero
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads, new value visible right after the write edge
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // execute must hand over a clean destination on every write
    a_waddr_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        we |-> !$isunknown(waddr)
    );

endmodule : regfile

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  instr_valid,
    input  lc3b_types::lc3b_word instr,
    output lc3b_types::lc3b_reg  raddr1,
    output lc3b_types::lc3b_reg  raddr2,
    input  lc3b_types::lc3b_word rdata1,
    input  lc3b_types::lc3b_word rdata2,
    ex_bus_if.decode             bus
);

    logic                         ir_valid;
    lc3b_types::lc3b_word         ir;
    lc3b_types::lc3b_control_word ctrl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_valid <= 1'b0;
        end else begin
            ir_valid <= instr_valid;   // one instruction per cycle, never refused
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ir <= instr;
        end
    end

    control_rom control_rom_i (
        .ir   (ir),
        .ctrl (ctrl)
    );

    assign raddr1 = ctrl.regfile_sr1;
    assign raddr2 = ctrl.regfile_sr2;

    always_comb begin
        if (ctrl.alu_mux_sel == lc3b_types::lc3b_alu_mux_sel_imm4) begin
            bus.imm = {12'b0, ir[3:0]};           // shift amount
        end else begin
            bus.imm = {{11{ir[4]}}, ir[4:0]};     // imm5 sext
        end
    end

    assign bus.valid    = ir_valid;
    assign bus.ctrl     = ctrl;
    assign bus.sr1_data = rdata1;
    assign bus.sr2_data = rdata2;

endmodule : decode_stage

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire                  clk,
    input  wire                  rst_n,
    ex_bus_if.execute            bus,
    output logic                 we,
    output lc3b_types::lc3b_reg  waddr,
    output lc3b_types::lc3b_word wdata,
    output logic                 wb_valid,
    output lc3b_types::lc3b_reg  wb_dest,
    output lc3b_types::lc3b_word wb_data,
    output lc3b_types::lc3b_cc   cc
);

    lc3b_types::lc3b_word alu_a;
    lc3b_types::lc3b_word alu_b;
    lc3b_types::lc3b_word alu_out;
    logic [3:0]           shamt;
    lc3b_types::lc3b_cc   cc_next;
    logic                 load;

    assign alu_a = bus.sr1_data;

    always_comb begin
        case (bus.ctrl.alu_mux_sel)
            lc3b_types::lc3b_alu_mux_sel_imm5,
            lc3b_types::lc3b_alu_mux_sel_imm4: alu_b = bus.imm;
            default:                           alu_b = bus.sr2_data;
        endcase
    end

    assign shamt = alu_b[3:0];   // only the low nibble shifts

    always_comb begin
        case (bus.ctrl.alu_op)
            lc3b_types::lc3b_alu_op_add: alu_out = alu_a + alu_b;   // wraps at 16 bits
            lc3b_types::lc3b_alu_op_and: alu_out = alu_a & alu_b;
            lc3b_types::lc3b_alu_op_not: alu_out = ~alu_a;
            lc3b_types::lc3b_alu_op_sll: alu_out = alu_a << shamt;
            lc3b_types::lc3b_alu_op_srl: alu_out = alu_a >> shamt;
            lc3b_types::lc3b_alu_op_sra: alu_out = lc3b_types::lc3b_word'($signed(alu_a) >>> shamt);
            default:                     alu_out = alu_a;
        endcase
    end

    assign cc_next = {alu_out[15], alu_out == '0, !alu_out[15] && (alu_out != '0)};

    assign load = bus.valid && bus.ctrl.regfile_load;

    // register file is written at the same edge as the writeback registers
    assign we    = load;
    assign waddr = bus.ctrl.regfile_dest;
    assign wdata = alu_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            cc       <= lc3b_types::CC_RESET;
        end else begin
            wb_valid <= load;
            if (bus.valid && bus.ctrl.cc_load) begin
                cc <= cc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wb_dest <= bus.ctrl.regfile_dest;
            wb_data <= alu_out;
        end
    end

    a_wb_data_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_valid |-> !$isunknown(wb_data)
    );

endmodule : execute_stage

`default_nettype wire

// ==== src/lc3b_alu_pipe.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc3b_alu_pipe (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  instr_valid,
    input  lc3b_types::lc3b_word instr,
    output logic                 wb_valid,
    output lc3b_types::lc3b_reg  wb_dest,
    output lc3b_types::lc3b_word wb_data,
    output lc3b_types::lc3b_cc   cc
);

    lc3b_types::lc3b_reg  raddr1;
    lc3b_types::lc3b_reg  raddr2;
    lc3b_types::lc3b_word rdata1;
    lc3b_types::lc3b_word rdata2;
    logic                 rf_we;
    lc3b_types::lc3b_reg  rf_waddr;
    lc3b_types::lc3b_word rf_wdata;

    ex_bus_if ex_bus ();

    decode_stage decode_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .bus         (ex_bus.decode)
    );

    execute_stage execute_stage_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (ex_bus.execute),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata),
        .wb_valid (wb_valid),
        .wb_dest  (wb_dest),
        .wb_data  (wb_data),
        .cc       (cc)
    );

    regfile regfile_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

endmodule : lc3b_alu_pipe

`default_nettype wire

// ==== verif/lc3b_alu_pipe_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lc3b_alu_pipe_tb;

    localparam int DRIVE_DELAY = 2;
    localparam int NUM_RANDOM  = 400;
    localparam int NUM_INSTR   = 1 + 12 + 68 + 28 + 22 + NUM_RANDOM;
    localparam int MAX_CYCLES  = 2 * NUM_INSTR + 100;
    localparam lc3b_types::lc3b_cc CC_AT_RESET = 3'b010;   // Z

    logic                 clk;
    logic                 rst_n;
    logic                 instr_valid;
    lc3b_types::lc3b_word instr;
    logic                 wb_valid;
    lc3b_types::lc3b_reg  wb_dest;
    lc3b_types::lc3b_word wb_data;
    lc3b_types::lc3b_cc   cc;

    lc3b_types::lc3b_word model_regs [8];
    lc3b_types::lc3b_cc   model_cc;
    string                test_name;
    int                   cycle = 0;
    int                   errors = 0;
    int                   checks = 0;

    // one entry per writing instruction, in issue order
    lc3b_types::lc3b_reg  exp_dest_q [$];
    lc3b_types::lc3b_word exp_data_q [$];
    lc3b_types::lc3b_cc   exp_cc_q [$];
    int                   exp_cycle_q [$];
    string                exp_name_q [$];

    lc3b_alu_pipe lc3b_alu_pipe_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .cc          (cc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic lc3b_types::lc3b_word reg_form(input logic [3:0] op,
            input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg sr1,
            input lc3b_types::lc3b_reg sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic lc3b_types::lc3b_word imm_form(input logic [3:0] op,
            input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg sr1,
            input logic [4:0] imm5);
        return {op, dr, sr1, 1'b1, imm5};
    endfunction

    function automatic lc3b_types::lc3b_word shift_form(input lc3b_types::lc3b_reg dr,
            input lc3b_types::lc3b_reg sr, input logic right, input logic arith,
            input logic [3:0] amt);
        return {4'b1101, dr, sr, arith, right, amt};   // bit 5 A, bit 4 D
    endfunction

    // ISA meaning of one word against the model state, 0 when nothing is written
    function automatic logic reference(input lc3b_types::lc3b_word word,
            output lc3b_types::lc3b_reg dest, output lc3b_types::lc3b_word data,
            output lc3b_types::lc3b_cc flags);
        lc3b_types::lc3b_word a;
        lc3b_types::lc3b_word b;
        logic                 writes;
        a      = model_regs[word[8:6]];
        b      = word[5] ? {{11{word[4]}}, word[4:0]} : model_regs[word[2:0]];
        dest   = word[11:9];
        writes = 1'b1;
        case (word[15:12])
            4'b0001: data = a + b;
            4'b0101: data = a & b;
            4'b1001: data = ~a;
            4'b1101: begin
                if (!word[4]) begin
                    data = a << word[3:0];
                end else if (!word[5]) begin
                    data = a >> word[3:0];
                end else begin
                    data = $signed(a) >>> word[3:0];   // sign bit copied in
                end
            end
            default: begin
                data   = '0;
                writes = 1'b0;
            end
        endcase
        flags = {data[15], data == 16'h0, !data[15] && data != 16'h0};
        return writes;
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        $display("-- test %s", name);
    endtask

    task automatic issue(input lc3b_types::lc3b_word word);
        lc3b_types::lc3b_reg  dest;
        lc3b_types::lc3b_word data;
        lc3b_types::lc3b_cc   flags;
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid = 1'b1;
        instr       = word;
        if (reference(word, dest, data, flags)) begin
            model_regs[dest] = data;   // next instruction reads the new value
            model_cc         = flags;
            exp_dest_q.push_back(dest);
            exp_data_q.push_back(data);
            exp_cc_q.push_back(flags);
            exp_cycle_q.push_back(cycle + 2);   // one cycle after the accepting edge
            exp_name_q.push_back(test_name);
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #DRIVE_DELAY;
        instr_valid = 1'b0;
        instr       = 16'($urandom);   // junk, must be ignored
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle();
        while (exp_data_q.size() != 0 && waited < 8) begin
            @(posedge clk);
            waited++;
        end
        #DRIVE_DELAY;
        checks++;
        assert (exp_data_q.size() == 0) else begin
            errors++;
            $display("%0d expected writebacks never arrived in test %s",
                     exp_data_q.size(), test_name);
            exp_dest_q.delete();
            exp_data_q.delete();
            exp_cc_q.delete();
            exp_cycle_q.delete();
            exp_name_q.delete();
        end
    endtask

    always @(negedge clk) begin : check_writeback
        string                name;
        lc3b_types::lc3b_reg  dest;
        lc3b_types::lc3b_word data;
        lc3b_types::lc3b_cc   flags;
        int                   due;
        if (rst_n && wb_valid) begin
            checks++;
            assert (exp_data_q.size() != 0) else begin
                errors++;
                $display("writeback to R%0d arrived with no instruction outstanding", wb_dest);
            end
            if (exp_data_q.size() != 0) begin
                name  = exp_name_q.pop_front();
                dest  = exp_dest_q.pop_front();
                data  = exp_data_q.pop_front();
                flags = exp_cc_q.pop_front();
                due   = exp_cycle_q.pop_front();
                checks += 4;
                assert (wb_dest === dest) else begin
                    errors++;
                    $display("FAIL %s dest exp R%0d got R%0d", name, dest, wb_dest);
                end
                assert (wb_data === data) else begin
                    errors++;
                    $display("FAIL %s data exp %h got %h", name, data, wb_data);
                end
                assert (cc === flags) else begin
                    errors++;
                    $display("FAIL %s cc exp %b got %b", name, flags, cc);
                end
                assert (cycle == due) else begin
                    errors++;
                    $display("FAIL %s latency exp cycle %0d got cycle %0d", name, due, cycle);
                end
            end
        end
    end

    initial begin
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
        end
        $display("run stopped after %0d cycles without finishing", cycle);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        lc3b_types::lc3b_word word;
        void'($urandom(32'hd0f0_84ed));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        model_cc    = CC_AT_RESET;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;

        begin_test("reset");
        repeat (3) begin
            @(negedge clk);
            checks++;
            assert (wb_valid === 1'b0 && cc === CC_AT_RESET) else begin
                errors++;
                $display("FAIL reset wb_valid/cc exp 0/%b got %b/%b", CC_AT_RESET, wb_valid, cc);
            end
        end
        issue(imm_form(4'b1001, 3'd1, 3'd0, 5'h1f));   // NOT R1 = ffff
        drain();

        begin_test("add_and");
        issue(imm_form(4'b0101, 3'd2, 3'd2, 5'd0));
        issue(imm_form(4'b0001, 3'd2, 3'd2, -5'sd7));
        issue(imm_form(4'b0001, 3'd3, 3'd3, 5'd15));
        issue(reg_form(4'b0001, 3'd4, 3'd2, 3'd3));
        issue(reg_form(4'b0101, 3'd5, 3'd1, 3'd2));
        issue(imm_form(4'b0001, 3'd6, 3'd2, 5'b10000));   // -16
        issue(imm_form(4'b0101, 3'd7, 3'd1, -5'sd3));
        issue(imm_form(4'b0001, 3'd0, 3'd1, 5'd1));      // wraps to zero
        issue(reg_form(4'b0001, 3'd0, 3'd6, 3'd6));
        issue(reg_form(4'b0101, 3'd4, 3'd3, 3'd2));
        issue(imm_form(4'b0101, 3'd5, 3'd6, 5'd10));
        issue(reg_form(4'b0001, 3'd7, 3'd3, 3'd3));
        drain();

        begin_test("shift");
        issue(imm_form(4'b0101, 3'd2, 3'd2, 5'd0));
        issue(imm_form(4'b0001, 3'd2, 3'd2, -5'sd13));
        issue(imm_form(4'b0101, 3'd3, 3'd3, 5'd0));
        issue(imm_form(4'b0001, 3'd3, 3'd3, 5'd13));
        for (int k = 0; k < 16; k++) begin
            issue(shift_form(3'd5, 3'd2, 1'b0, k[0], 4'(k)));   // A bit ignored for sll
            issue(shift_form(3'd6, 3'd2, 1'b1, 1'b0, 4'(k)));
            issue(shift_form(3'd7, 3'd2, 1'b1, 1'b1, 4'(k)));
            issue(shift_form(3'd4, 3'd3, 1'b1, 1'b1, 4'(k)));
        end
        drain();

        begin_test("back_to_back");
        issue(imm_form(4'b0101, 3'd1, 3'd1, 5'd0));
        for (int k = 0; k < 20; k++) begin
            issue(imm_form(4'b0001, 3'd1, 3'd1, 5'd3));
        end
        issue(reg_form(4'b0001, 3'd2, 3'd1, 3'd1));
        issue(imm_form(4'b0101, 3'd3, 3'd2, -5'sd2));
        issue(imm_form(4'b1001, 3'd4, 3'd3, 5'h1f));
        issue(shift_form(3'd5, 3'd4, 1'b0, 1'b0, 4'd3));
        issue(reg_form(4'b0001, 3'd1, 3'd5, 3'd4));
        issue(shift_form(3'd6, 3'd1, 1'b1, 1'b1, 4'd2));
        issue(reg_form(4'b0001, 3'd6, 3'd6, 3'd1));
        drain();

        begin_test("non_alu");
        issue(imm_form(4'b0101, 3'd1, 3'd1, 5'd0));
        issue(imm_form(4'b0001, 3'd1, 3'd1, 5'd1));   // leaves P set, R0 is negative
        for (int op = 0; op < 16; op++) begin
            if (op != 1 && op != 5 && op != 9 && op != 13) begin
                issue({4'(op), 12'($urandom)});
            end
        end
        drain();
        checks++;
        assert (cc === model_cc) else begin
            errors++;
            $display("FAIL non_alu cc exp %b got %b", model_cc, cc);
        end
        for (int r = 0; r < 8; r++) begin
            issue(imm_form(4'b0001, 3'(r), 3'(r), 5'd0));   // registers untouched
        end
        drain();

        begin_test("random");
        for (int n = 0; n < NUM_RANDOM; n++) begin
            word = 16'($urandom);
            case ($urandom_range(0, 3))
                0: word[15:12] = 4'b0001;
                1: word[15:12] = 4'b0101;
                2: word = {4'b1001, word[11:6], 6'h3f};
                default: word[15:12] = 4'b1101;
            endcase
            if ($urandom_range(0, 3) == 0) begin
                idle();
            end
            issue(word);
        end
        drain();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : lc3b_alu_pipe_tb

`default_nettype wire

// ==== lc3b_alu_pipe.f ====
src/lc3b_types.sv
src/ex_bus_if.sv
src/control_rom.sv
src/regfile.sv
src/decode_stage.sv
src/execute_stage.sv
src/lc3b_alu_pipe.sv
verif/lc3b_alu_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: lc3b_alu_pipe

sources:
  - files:
      - src/lc3b_types.sv
      - src/ex_bus_if.sv
      - src/control_rom.sv
      - src/regfile.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/lc3b_alu_pipe.sv
  - target: test
    files:
      - verif/lc3b_alu_pipe_tb.sv
